// File: hdl/ebusPkg.sv
package ebusPkg;

  // Machine word and the APB address that reaches the EBUS
  localparam int wordWidth = 36;
  localparam int addrWidth = 6;

  // Number of interrupt levels on the PI, also the APR flag count
  localparam int numLevels = 7;

  // Device codes carried in paddr[5:4]
  localparam logic [1:0] devApr = 2'd0;
  localparam logic [1:0] devPi  = 2'd1;

  // EBUS function codes carried in paddr[3:2]
  localparam logic [1:0] fnDatao = 2'd0;
  localparam logic [1:0] fnDatai = 2'd1;
  localparam logic [1:0] fnCono  = 2'd2;
  localparam logic [1:0] fnConi  = 2'd3;

  // Field layout of a CONO word, most significant field first
  typedef struct packed {
    logic [23:0]          reserved;
    logic                 clearAll;
    logic                 sysOn;
    logic                 sysOff;
    logic                 setSel;
    logic                 clrSel;
    logic [numLevels-1:0] levelSel;
  } conoFields;

  // The same 36 bits are plain data for DATAO and a command for CONO
  typedef union packed {
    logic [wordWidth-1:0] raw;
    conoFields            cono;
  } ebusWord;

endpackage

// File: hdl/ebusDecode.sv
`timescale 1ns/1ps

module ebusDecode (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         psel,
  input  logic                         penable,
  input  logic                         pwrite,
  input  logic [ebusPkg::addrWidth-1:0] paddr,
  input  logic [ebusPkg::wordWidth-1:0] pwdata,
  output logic                         aprSel,
  output logic                         piSel,
  output logic [1:0]                   func,
  output logic [ebusPkg::wordWidth-1:0] wdata,
  output logic                         xfer,
  output logic                         xferErr
);

  import ebusPkg::*;

  logic       setup;
  logic [1:0] dev;
  logic [1:0] fn;
  logic       isRead;
  logic       devBad;
  logic       dirBad;
  logic       piDatao;
  logic       illegal;
  ebusWord    wdataReg;

  // The setup phase lasts exactly one cycle, so one operation is issued per transfer
  assign setup = psel && !penable;

  // Low two address bits are byte offsets and play no part in the decode
  assign dev = paddr[5:4];
  assign fn  = paddr[3:2];

  assign isRead  = (fn == fnDatai) || (fn == fnConi);
  assign devBad  = (dev != devApr) && (dev != devPi);
  assign dirBad  = (pwrite == isRead);

  // The PI has no data register
  assign piDatao = (dev == devPi) && (fn == fnDatao);

  assign illegal = devBad || dirBad || piDatao;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      aprSel  <= 1'b0;
      piSel   <= 1'b0;
      xfer    <= 1'b0;
      xferErr <= 1'b0;
    end else begin
      xfer    <= setup;
      xferErr <= setup && illegal;
      // A rejected access strobes no device, so no state can change
      aprSel  <= setup && !illegal && (dev == devApr);
      piSel   <= setup && !illegal && (dev == devPi);
    end
  end

  // Function and write word are only looked at while a strobe is high
  always_ff @(posedge clk) begin
    if (setup) begin
      func         <= fn;
      wdataReg.raw <= pwdata;
    end
  end

  assign wdata = wdataReg.raw;

endmodule

// File: hdl/aprDevice.sv
`timescale 1ns/1ps

module aprDevice (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         aprSel,
  input  logic [1:0]                   func,
  input  logic [ebusPkg::wordWidth-1:0] wdata,
  output logic                         aprDrive,
  output logic [ebusPkg::wordWidth-1:0] aprData,
  output logic                         aprIrq
);

  import ebusPkg::*;

  ebusWord              cmd;
  logic [wordWidth-1:0] dataReg;
  logic [numLevels-1:0] flags;
  logic [numLevels-1:0] flagsNext;
  logic                 enable;
  logic                 doDatao;
  logic                 doCono;

  assign cmd.raw = wdata;

  assign doDatao = aprSel && (func == fnDatao);
  assign doCono  = aprSel && (func == fnCono);

  // Only reads put the APR on the bus
  always_comb begin
    aprDrive = aprSel && ((func == fnDatai) || (func == fnConi));
    aprData  = '0;
    if (aprSel && (func == fnDatai)) begin
      aprData = dataReg;
    end else if (aprSel && (func == fnConi)) begin
      aprData = {{(wordWidth - numLevels - 1){1'b0}}, enable, flags};
    end
  end

  // Set is applied first so that a clear of the same flag wins
  always_comb begin
    flagsNext = flags;
    if (cmd.cono.clearAll) begin
      flagsNext = '0;
    end else begin
      if (cmd.cono.setSel) flagsNext = flagsNext | cmd.cono.levelSel;
      if (cmd.cono.clrSel) flagsNext = flagsNext & ~cmd.cono.levelSel;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      dataReg <= '0;
      flags   <= '0;
      enable  <= 1'b0;
      aprIrq  <= 1'b0;
    end else begin
      if (doDatao) begin
        dataReg <= cmd.raw;
      end
      if (doCono) begin
        flags <= flagsNext;
        if (cmd.cono.sysOn)  enable <= 1'b1;
        if (cmd.cono.sysOff) enable <= 1'b0;
      end
      // Follows the stored state, so it trails a CONO by one cycle
      aprIrq <= enable && (|flags);
    end
  end

endmodule

// File: hdl/piDevice.sv
`timescale 1ns/1ps

module piDevice (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         piSel,
  input  logic [1:0]                   func,
  input  logic [ebusPkg::wordWidth-1:0] wdata,
  input  logic [ebusPkg::numLevels-1:0] intReq,
  output logic                         piDrive,
  output logic [ebusPkg::wordWidth-1:0] piData,
  output logic [2:0]                   piLevel
);

  import ebusPkg::*;

  ebusWord              cmd;
  logic                 sysEn;
  logic [numLevels-1:0] levelEn;
  logic [numLevels-1:0] levelEnNext;
  logic [numLevels-1:0] active;
  logic [2:0]           levelNext;
  logic                 doCono;

  assign cmd.raw = wdata;
  assign doCono  = piSel && (func == fnCono);

  // Requests only count on enabled levels and only with the system on
  assign active = sysEn ? (intReq & levelEn) : '0;

  // Level 1 is intReq[0] and beats every other level
  always_comb begin
    levelNext = 3'd0;
    for (int i = numLevels - 1; i >= 0; i--) begin
      if (active[i]) begin
        levelNext = 3'(i + 1);
      end
    end
  end

  // Clear beats set for the same level, as on the APR
  always_comb begin
    levelEnNext = levelEn;
    if (cmd.cono.setSel) levelEnNext = levelEnNext | cmd.cono.levelSel;
    if (cmd.cono.clrSel) levelEnNext = levelEnNext & ~cmd.cono.levelSel;
  end

  always_comb begin
    piDrive = piSel && ((func == fnDatai) || (func == fnConi));
    piData  = '0;
    if (piSel && (func == fnDatai)) begin
      piData = {{(wordWidth - 3){1'b0}}, piLevel};
    end else if (piSel && (func == fnConi)) begin
      // System enable in bit 14, level enables in 13:7, active levels in 6:0
      piData = {{(wordWidth - 2 * numLevels - 1){1'b0}}, sysEn, levelEn, active};
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      sysEn   <= 1'b0;
      levelEn <= '0;
      piLevel <= 3'd0;
    end else begin
      if (doCono) begin
        if (cmd.cono.clearAll) begin
          sysEn   <= 1'b0;
          levelEn <= '0;
        end else begin
          levelEn <= levelEnNext;
          if (cmd.cono.sysOn)  sysEn <= 1'b1;
          if (cmd.cono.sysOff) sysEn <= 1'b0;
        end
      end
      piLevel <= levelNext;
    end
  end

endmodule

// File: hdl/ebusResult.sv
`timescale 1ns/1ps

module ebusResult (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         xfer,
  input  logic                         xferErr,
  input  logic                         aprDrive,
  input  logic [ebusPkg::wordWidth-1:0] aprData,
  input  logic                         piDrive,
  input  logic [ebusPkg::wordWidth-1:0] piData,
  output logic [ebusPkg::wordWidth-1:0] prdata,
  output logic                         pready,
  output logic                         pslverr
);

  import ebusPkg::*;

  logic [wordWidth-1:0] busData;

  // Several devices can drive the EBUS, so the bus itself lives here.
  // Writes and rejected accesses leave the bus idle and read as zero
  always_comb begin
    if (aprDrive)     busData = aprData;
    else if (piDrive) busData = piData;
    else              busData = '0;
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pready  <= 1'b0;
      pslverr <= 1'b0;
    end else begin
      // One wait state, then a single-cycle response
      pready  <= xfer;
      pslverr <= xferErr;
    end
  end

  always_ff @(posedge clk) begin
    if (xfer) begin
      prdata <= busData;
    end
  end

endmodule

// File: hdl/ebusTop.sv
`timescale 1ns/1ps

module ebusTop (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         psel,
  input  logic                         penable,
  input  logic                         pwrite,
  input  logic [ebusPkg::addrWidth-1:0] paddr,
  input  logic [ebusPkg::wordWidth-1:0] pwdata,
  output logic [ebusPkg::wordWidth-1:0] prdata,
  output logic                         pready,
  output logic                         pslverr,
  input  logic [ebusPkg::numLevels-1:0] intReq,
  output logic [2:0]                   piLevel,
  output logic                         aprIrq
);

  import ebusPkg::*;

  logic                 aprSel;
  logic                 piSel;
  logic [1:0]           func;
  logic [wordWidth-1:0] wdata;
  logic                 xfer;
  logic                 xferErr;
  logic                 aprDrive;
  logic [wordWidth-1:0] aprData;
  logic                 piDrive;
  logic [wordWidth-1:0] piData;

  // APB setup phase becomes one EBUS operation
  ebusDecode ebusDecode_inst (
    .clk     (clk),
    .rstN    (rstN),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .aprSel  (aprSel),
    .piSel   (piSel),
    .func    (func),
    .wdata   (wdata),
    .xfer    (xfer),
    .xferErr (xferErr)
  );

  aprDevice aprDevice_inst (
    .clk      (clk),
    .rstN     (rstN),
    .aprSel   (aprSel),
    .func     (func),
    .wdata    (wdata),
    .aprDrive (aprDrive),
    .aprData  (aprData),
    .aprIrq   (aprIrq)
  );

  piDevice piDevice_inst (
    .clk     (clk),
    .rstN    (rstN),
    .piSel   (piSel),
    .func    (func),
    .wdata   (wdata),
    .intReq  (intReq),
    .piDrive (piDrive),
    .piData  (piData),
    .piLevel (piLevel)
  );

  // Bus mux and APB response
  ebusResult ebusResult_inst (
    .clk      (clk),
    .rstN     (rstN),
    .xfer     (xfer),
    .xferErr  (xferErr),
    .aprDrive (aprDrive),
    .aprData  (aprData),
    .piDrive  (piDrive),
    .piData   (piData),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr)
  );

endmodule

// File: verification/ebusTop_sva.sv
`timescale 1ns/1ps

module ebusTopSva (
  input logic                         clk,
  input logic                         rstN,
  input logic                         psel,
  input logic                         penable,
  input logic                         pready,
  input logic                         pslverr,
  input logic                         aprIrq,
  input logic [ebusPkg::numLevels-1:0] intReq,
  input logic [2:0]                   piLevel
);

  // Read by the testbench on every clock and at the end of the run
  int failCount = 0;

  // The slave may only answer inside an access phase
  readyInAccess: assert property (@(posedge clk) disable iff (!rstN)
    pready |-> (psel && penable))
    else begin $error("pready outside an access phase"); failCount++; end

  // Exactly one wait state, so pready is high only in the second access cycle
  readyAfterEnable: assert property (@(posedge clk) disable iff (!rstN)
    pready == ($past(penable) && !$past(penable, 2)))
    else begin $error("pready not in the second access cycle"); failCount++; end

  // Fixed latency from the start of setup to the response
  readyLatency: assert property (@(posedge clk) disable iff (!rstN)
    $rose(pready) |-> ($past(psel, 2) && !$past(psel, 3)))
    else begin $error("pready latency from psel is wrong"); failCount++; end

  errWithReady: assert property (@(posedge clk) disable iff (!rstN)
    pslverr |-> pready)
    else begin $error("pslverr without pready"); failCount++; end

  // A reported level is one of the seven and was requested on the cycle before
  levelRequested: assert property (@(posedge clk) disable iff (!rstN)
    (piLevel != 3'd0) |-> ((($past(intReq) >> (piLevel - 3'd1)) & 7'd1) != 7'd0))
    else begin $error("piLevel names a level that was not requested"); failCount++; end

  // Outputs come out of reset quiet
  quietAfterReset: assert property (@(posedge clk)
    $rose(rstN) |-> (!pready && !aprIrq && piLevel == 3'd0))
    else begin $error("outputs not cleared by reset"); failCount++; end

endmodule

bind ebusTop ebusTopSva ebusTopSva_inst (
  .clk     (clk),
  .rstN    (rstN),
  .psel    (psel),
  .penable (penable),
  .pready  (pready),
  .pslverr (pslverr),
  .aprIrq  (aprIrq),
  .intReq  (intReq),
  .piLevel (piLevel)
);

// File: verification/ebusTopTb.sv
`timescale 1ns/1ps

module ebusTopTb;

  import ebusPkg::*;

  // About 100 transfers of four cycles plus reset is near 420 cycles
  localparam int maxCycles = 1200;

  logic                 clk;
  logic                 rstN;
  logic                 psel;
  logic                 penable;
  logic                 pwrite;
  logic [addrWidth-1:0] paddr;
  logic [wordWidth-1:0] pwdata;
  logic [wordWidth-1:0] prdata;
  logic                 pready;
  logic                 pslverr;
  logic [numLevels-1:0] intReq;
  logic [2:0]           piLevel;
  logic                 aprIrq;

  int seed = 899;
  int cycleCount = 0;

  // Reference model of the device state
  logic [wordWidth-1:0] modelAprData;
  logic [numLevels-1:0] modelAprFlags;
  logic                 modelAprEn;
  logic                 modelPiSysEn;
  logic [numLevels-1:0] modelPiLevelEn;

  ebusTop ebusTop_inst (
    .clk     (clk),
    .rstN    (rstN),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .intReq  (intReq),
    .piLevel (piLevel),
    .aprIrq  (aprIrq)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= maxCycles) begin
      $display("Simulation timed out after %0d cycles", cycleCount);
      $display("*** FAILED ***");
      $fatal(1, "Timeout");
    end else if (ebusTop_inst.ebusTopSva_inst.failCount != 0) begin
      $display("A bound protocol assertion failed");
      $display("*** FAILED ***");
      $fatal(1, "Bound assertion failed");
    end
  end

  task automatic checkValue(input string name, input logic [wordWidth-1:0] expected,
                            input logic [wordWidth-1:0] actual);
    assert (actual === expected) else begin
      $display("[ERROR] %s expected %h got %h", name, expected, actual);
      $display("*** FAILED ***");
      $fatal(1, "Check failed");
    end
  endtask

  function automatic logic [wordWidth-1:0] randWord();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = $random(seed);
    lo = $random(seed);
    return {hi[3:0], lo};
  endfunction

  // CONO fields from bit 11 down are clearAll, sysOn, sysOff, setSel, clrSel and levelSel
  function automatic logic [wordWidth-1:0] conoWord(input logic clearAll, input logic sysOn,
      input logic sysOff, input logic setSel, input logic clrSel, input logic [6:0] sel);
    return {24'd0, clearAll, sysOn, sysOff, setSel, clrSel, sel};
  endfunction

  function automatic logic [wordWidth-1:0] aprConiWord();
    return {28'd0, modelAprEn, modelAprFlags};
  endfunction

  function automatic logic [wordWidth-1:0] piConiWord();
    logic [numLevels-1:0] act;
    act = modelPiSysEn ? (intReq & modelPiLevelEn) : '0;
    return {21'd0, modelPiSysEn, modelPiLevelEn, act};
  endfunction

  // Lowest requested and enabled level wins, level 1 being intReq[0]
  function automatic logic [2:0] expectedLevel();
    logic [2:0] level;
    int k;
    level = 3'd0;
    for (k = 0; k < numLevels; k++) begin
      if (modelPiSysEn && intReq[k] && modelPiLevelEn[k] && level == 3'd0) level = 3'(k + 1);
    end
    return level;
  endfunction

  task automatic applyAprCono(input logic [wordWidth-1:0] word);
    logic [numLevels-1:0] setMask;
    logic [numLevels-1:0] clrMask;
    setMask = word[8] ? word[6:0] : '0;
    clrMask = word[7] ? word[6:0] : '0;
    if (word[11]) modelAprFlags = '0;
    else modelAprFlags = (modelAprFlags | setMask) & ~clrMask;
    if (word[10]) modelAprEn = 1'b1;
    if (word[9]) modelAprEn = 1'b0;
  endtask

  task automatic applyPiCono(input logic [wordWidth-1:0] word);
    logic [numLevels-1:0] setMask;
    logic [numLevels-1:0] clrMask;
    setMask = word[8] ? word[6:0] : '0;
    clrMask = word[7] ? word[6:0] : '0;
    if (word[11]) begin
      modelPiSysEn = 1'b0;
      modelPiLevelEn = '0;
    end else begin
      modelPiLevelEn = (modelPiLevelEn | setMask) & ~clrMask;
      if (word[10]) modelPiSysEn = 1'b1;
      if (word[9]) modelPiSysEn = 1'b0;
    end
  endtask

  // Setup phase, then access phase held until pready
  task automatic apbTransfer(input logic write, input logic [1:0] dev, input logic [1:0] fn,
      input logic [wordWidth-1:0] data, output logic [wordWidth-1:0] rdata, output logic err);
    @(posedge clk);
    #1;
    psel = 1'b1;
    penable = 1'b0;
    pwrite = write;
    paddr = {dev, fn, 2'b00};
    pwdata = data;
    @(posedge clk);
    #1;
    penable = 1'b1;
    do begin
      @(posedge clk);
      #1;
    end while (!pready);
    rdata = prdata;
    err = pslverr;
    @(posedge clk);
    #1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic apbWrite(input logic [1:0] dev, input logic [1:0] fn,
                          input logic [wordWidth-1:0] data, input logic expErr);
    logic [wordWidth-1:0] rdata;
    logic                 err;
    apbTransfer(1'b1, dev, fn, data, rdata, err);
    checkValue("pslverr", 36'(expErr), 36'(err));
    checkValue("prdata", '0, rdata);
  endtask

  task automatic apbRead(input logic [1:0] dev, input logic [1:0] fn,
                         input logic [wordWidth-1:0] expData, input logic expErr);
    logic [wordWidth-1:0] rdata;
    logic                 err;
    apbTransfer(1'b0, dev, fn, '0, rdata, err);
    checkValue("pslverr", 36'(expErr), 36'(err));
    checkValue("prdata", expData, rdata);
  endtask

  task automatic checkOutputs();
    checkValue("aprIrq", 36'(modelAprEn && (|modelAprFlags)), 36'(aprIrq));
    checkValue("piLevel", 36'(expectedLevel()), 36'(piLevel));
  endtask

  task automatic runAprData();
    int i;
    for (i = 0; i < 20; i++) begin
      modelAprData = randWord();
      apbWrite(devApr, fnDatao, modelAprData, 1'b0);
      apbRead(devApr, fnDatai, modelAprData, 1'b0);
    end
  endtask

  task automatic runAprControl();
    logic [31:0]          r;
    logic [wordWidth-1:0] word;
    int                   i;
    word = conoWord(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 7'h00);
    apbWrite(devApr, fnCono, word, 1'b0);
    applyAprCono(word);
    for (i = 0; i < 8; i++) begin
      r = $random(seed);
      word = conoWord(i == 5, r[10:9] == 2'd1, r[10:9] == 2'd0, r[7], r[8], r[6:0]);
      apbWrite(devApr, fnCono, word, 1'b0);
      applyAprCono(word);
      checkOutputs();
      apbRead(devApr, fnConi, aprConiWord(), 1'b0);
    end
  endtask

  task automatic runPiLevels();
    logic [31:0]          r;
    logic [wordWidth-1:0] word;
    int                   i;
    word = conoWord(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 7'h00);
    apbWrite(devPi, fnCono, word, 1'b0);
    applyPiCono(word);
    word = conoWord(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 7'h00);
    apbWrite(devPi, fnCono, word, 1'b0);
    applyPiCono(word);
    for (i = 0; i < 8; i++) begin
      r = $random(seed);
      word = conoWord(1'b0, 1'b0, 1'b0, r[7], r[8], r[6:0]);
      apbWrite(devPi, fnCono, word, 1'b0);
      applyPiCono(word);
      @(posedge clk);
      #1;
      intReq = r[22:16];
      @(posedge clk);
      #1;
      checkOutputs();
      apbRead(devPi, fnDatai, {33'd0, expectedLevel()}, 1'b0);
      apbRead(devPi, fnConi, piConiWord(), 1'b0);
    end
    // With the system off no level may be reported
    word = conoWord(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 7'h00);
    apbWrite(devPi, fnCono, word, 1'b0);
    applyPiCono(word);
    checkOutputs();
    apbRead(devPi, fnConi, piConiWord(), 1'b0);
  endtask

  task automatic runIllegal();
    logic [wordWidth-1:0] word;
    logic [wordWidth-1:0] harm;
    word = conoWord(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 7'h00);
    apbWrite(devPi, fnCono, word, 1'b0);
    applyPiCono(word);
    // Would wipe every flag and enable if it reached a device
    harm = conoWord(1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 7'h7f);
    apbWrite(2'd2, fnDatao, randWord(), 1'b1);
    apbRead(2'd3, fnConi, '0, 1'b1);
    apbWrite(2'd3, fnCono, harm, 1'b1);
    apbWrite(devApr, fnDatai, ~modelAprData, 1'b1);
    apbRead(devApr, fnDatao, '0, 1'b1);
    apbWrite(devApr, fnConi, harm, 1'b1);
    apbRead(devPi, fnCono, '0, 1'b1);
    apbWrite(devPi, fnDatao, harm, 1'b1);
    apbRead(devApr, fnDatai, modelAprData, 1'b0);
    apbRead(devApr, fnConi, aprConiWord(), 1'b0);
    apbRead(devPi, fnConi, piConiWord(), 1'b0);
    checkOutputs();
  endtask

  initial begin
    rstN = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    intReq = '0;
    modelAprData = '0;
    modelAprFlags = '0;
    modelAprEn = 1'b0;
    modelPiSysEn = 1'b0;
    modelPiLevelEn = '0;
    repeat (10) @(posedge clk);
    #1;
    rstN = 1'b1;
    runAprData();
    runAprControl();
    runPiLevels();
    runIllegal();
    repeat (2) @(posedge clk);
    if (ebusTop_inst.ebusTopSva_inst.failCount == 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      $display("*** FAILED ***");
      $fatal(1, "Bound assertions reported failures");
    end
  end

endmodule

// File: ebusTop.f
hdl/ebusPkg.sv
hdl/ebusDecode.sv
hdl/aprDevice.sv
hdl/piDevice.sv
hdl/ebusResult.sv
hdl/ebusTop.sv
verification/ebusTop_sva.sv
verification/ebusTopTb.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" &&
verilator --binary --assert -f ebusTop.f --top-module ebusTopTb -o ebusSim &&
./obj_dir/ebusSim | tee /dev/stderr | grep -qF '*** PASSED ***' &&
echo "Simulation run passed" ||
{ echo "Simulation run failed"; exit 1; }
